// File: Makefile
# Verilator build and run for the writeback back end

VERILATOR ?= verilator
TOP       ?= tb_wb_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(filter-out +%,$(shell cat build.f))
HDRS := $(wildcard verilog/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, a header or the file list changes
$(BIN): build.f $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f build.f

# The log decides pass or fail, so a crash without the pass line also fails
run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
+incdir+verilog
verilog/wb_pkg.sv
verilog/axi_lite_if.sv
verilog/wb_stage.sv
verilog/wb_lsu.sv
verilog/wb_data_ram.sv
verilog/wb_regfile.sv
verilog/wb_retire_counters.sv
verilog/wb_top.sv
test/tb_wb_top.sv

// File: test/tb_wb_top.sv
/*
 * Random-stimulus testbench for the writeback back end
 * Galois LFSR stimulus, register, memory and counter model, value checker
 */
`include "wb_defs.svh"

module tb_wb_top import wb_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int          NUM_INSTR = 400;
  localparam int          MAX_WAIT  = 50;
  localparam int          MEM_AW    = $clog2(`WB_MEM_WORDS);
  localparam logic [31:0] MEM_BYTES = `WB_MEM_WORDS * 4;
  localparam logic [31:0] LFSR_SEED = 32'd51;
  // Taps for x^32 + x^22 + x^2 + x + 1 in right-shifting Galois form
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;

  // One instruction as the issuer sees it
  typedef struct packed {
    wb_instr_type_e kind;
    logic [31:0]    pc;
    logic           compressed;
    logic           count;
    logic [4:0]     rd;
    logic           rd_we;
    logic [31:0]    result;
    logic [31:0]    sdata;
  } tb_instr_t;

  logic           clk;
  logic           rst_n;
  logic           issue_valid;
  logic           issue_ready;
  wb_instr_type_e issue_type;
  logic [31:0]    issue_pc;
  logic           issue_compressed;
  logic           issue_count;
  logic [4:0]     issue_rd;
  logic           issue_rd_we;
  logic [31:0]    issue_result;
  logic [31:0]    issue_store_data;
  logic [4:0]     rf_raddr;
  logic [31:0]    rf_rdata;
  logic           instr_done;
  logic [31:0]    pc_wb;
  logic           outstanding_load;
  logic           outstanding_store;
  logic           lsu_err;
  logic [31:0]    retired;
  logic [31:0]    retired_c;

  // Reference model state
  logic [31:0] model_regs [32];
  logic [31:0] model_mem [`WB_MEM_WORDS];
  logic [31:0] model_ret;
  logic [31:0] model_ret_c;
  logic        model_err;

  // Issuer bookkeeping: cur is on the issue port, held sits in writeback
  tb_instr_t   cur;
  tb_instr_t   held;
  logic        presenting;
  logic        inflight;
  int          gap;
  int          issued;
  int          done_wait;
  int          ready_wait;
  logic [4:0]  raddr_q;
  logic [31:0] pc_next;
  logic [31:0] lfsr_state;

  wb_top uut (
    .clk_i (clk), .rst_ni (rst_n),
    .issue_valid_i (issue_valid), .issue_ready_o (issue_ready),
    .issue_type_i (issue_type), .issue_pc_i (issue_pc),
    .issue_compressed_i (issue_compressed), .issue_count_i (issue_count),
    .issue_rd_i (issue_rd), .issue_rd_we_i (issue_rd_we),
    .issue_result_i (issue_result), .issue_store_data_i (issue_store_data),
    .rf_raddr_i (rf_raddr), .rf_rdata_o (rf_rdata),
    .instr_done_o (instr_done), .pc_wb_o (pc_wb),
    .outstanding_load_o (outstanding_load), .outstanding_store_o (outstanding_store),
    .lsu_err_o (lsu_err), .retired_o (retired), .retired_compressed_o (retired_c)
  );

  always #2 clk = ~clk;

  // Each output bit costs one LFSR step
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  task automatic abort_run(string reason);
    $display("%s at %0t", reason, $time);
    $display("TESTS FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED t=%0t %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic clear_model();
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    for (int i = 0; i < `WB_MEM_WORDS; i++) begin
      model_mem[i] = '0;
    end
    model_ret   = '0;
    model_ret_c = '0;
    model_err   = 1'b0;
  endtask

  // Half the instructions are ALU results, the rest split between loads and stores
  task automatic make_instr();
    logic [31:0] r;
    r = take_bits(2);
    case (r[1:0])
      2'd0: cur.kind = WB_INSTR_LOAD;
      2'd1: cur.kind = WB_INSTR_STORE;
      default: cur.kind = WB_INSTR_OTHER;
    endcase
    r = take_bits(5);
    cur.rd = r[4:0];
    r = take_bits(2);
    cur.rd_we = (cur.kind == WB_INSTR_LOAD) | ((cur.kind == WB_INSTR_OTHER) & (r[1:0] != 2'd0));
    r = take_bits(3);
    cur.count = (r[2:0] != 3'd0);
    r = take_bits(1);
    cur.compressed = r[0];
    cur.pc = pc_next;
    pc_next = pc_next + (cur.compressed ? 32'd2 : 32'd4);
    r = take_bits(4);
    if (cur.kind == WB_INSTR_OTHER) begin
      cur.result = take_bits(32);
    end else if (r[3:0] == 4'd0) begin
      // About one access in sixteen lands above the memory
      r = take_bits(32);
      cur.result = {r[31:2] | 30'h40, 2'b00};
    end else begin
      r = take_bits(MEM_AW);
      cur.result = {{(30 - MEM_AW){1'b0}}, r[MEM_AW-1:0], 2'b00};
    end
    cur.sdata = take_bits(32);
    r = take_bits(2);
    gap = int'(r[1:0]);
  endtask

  // Apply the architectural effect of the instruction leaving writeback
  task automatic retire_instr();
    logic              mem_err;
    logic [MEM_AW-1:0] widx;
    widx    = held.result[MEM_AW+1:2];
    mem_err = (held.kind != WB_INSTR_OTHER) && (held.result >= MEM_BYTES);
    if (held.kind == WB_INSTR_OTHER && held.rd_we && held.rd != 5'd0) begin
      model_regs[held.rd] = held.result;
    end else if (held.kind == WB_INSTR_STORE && !mem_err) begin
      model_mem[widx] = held.sdata;
    end else if (held.kind == WB_INSTR_LOAD && !mem_err && held.rd != 5'd0) begin
      model_regs[held.rd] = model_mem[widx];
    end
    if (mem_err) begin
      model_err = 1'b1;
    end else if (held.count) begin
      model_ret = model_ret + 32'd1;
      if (held.compressed) model_ret_c = model_ret_c + 32'd1;
    end
  endtask

  // Outputs are sampled at the falling edge, inputs change on the rising edge
  task automatic run_cycle();
    logic [31:0] r;
    logic [4:0]  raddr_next;
    logic        accepted;
    @(negedge clk);
    // State seen here includes every retirement up to the previous cycle
    check_value("rf_rdata_o", rf_rdata, model_regs[raddr_q]);
    check_value("retired_o", retired, model_ret);
    check_value("retired_compressed_o", retired_c, model_ret_c);
    check_value("lsu_err_o", 32'(lsu_err), 32'(model_err));
    check_value("outstanding_load_o", 32'(outstanding_load),
                32'(inflight && held.kind == WB_INSTR_LOAD));
    check_value("outstanding_store_o", 32'(outstanding_store),
                32'(inflight && held.kind == WB_INSTR_STORE));
    if (inflight) begin
      check_value("pc_wb_o", pc_wb, held.pc);
      if (held.kind == WB_INSTR_OTHER) check_value("instr_done_o", 32'(instr_done), 32'd1);
      // A pending access keeps the issue port blocked
      if (!instr_done) check_value("issue_ready_o", 32'(issue_ready), 32'd0);
    end else begin
      check_value("instr_done_o", 32'(instr_done), 32'd0);
      check_value("issue_ready_o", 32'(issue_ready), 32'd1);
    end
    r = take_bits(5);
    raddr_next = r[4:0];
    if (inflight && instr_done) begin
      retire_instr();
      inflight   = 1'b0;
      done_wait  = 0;
      // Read back the destination on the next cycle
      raddr_next = held.rd;
    end else if (inflight) begin
      done_wait++;
      if (done_wait > MAX_WAIT) abort_run("Timeout waiting for instr_done_o");
    end
    accepted = presenting && issue_ready;
    if (presenting && !issue_ready) begin
      ready_wait++;
      if (ready_wait > MAX_WAIT) abort_run("Timeout waiting for issue_ready_o");
    end
    @(posedge clk);
    if (accepted) begin
      held       = cur;
      inflight   = 1'b1;
      presenting = 1'b0;
      ready_wait = 0;
    end
    if (!presenting && issued < NUM_INSTR) begin
      if (gap > 0) begin
        gap--;
      end else begin
        make_instr();
        presenting = 1'b1;
        issued++;
      end
    end
    // A held instruction keeps its fields until it is taken
    issue_valid      <= presenting;
    issue_type       <= cur.kind;
    issue_pc         <= cur.pc;
    issue_compressed <= cur.compressed;
    issue_count      <= cur.count;
    issue_rd         <= cur.rd;
    issue_rd_we      <= cur.rd_we;
    issue_result     <= cur.result;
    issue_store_data <= cur.sdata;
    rf_raddr         <= raddr_next;
    raddr_q           = raddr_next;
  endtask

  task automatic check_after_reset();
    @(negedge clk);
    check_value("issue_ready_o", 32'(issue_ready), 32'd1);
    check_value("instr_done_o", 32'(instr_done), 32'd0);
    check_value("outstanding_load_o", 32'(outstanding_load), 32'd0);
    check_value("outstanding_store_o", 32'(outstanding_store), 32'd0);
    check_value("lsu_err_o", 32'(lsu_err), 32'd0);
    check_value("retired_o", retired, 32'd0);
    check_value("retired_compressed_o", retired_c, 32'd0);
    check_value("rf_rdata_o", rf_rdata, model_regs[raddr_q]);
  endtask

  initial begin
    lfsr_state       = LFSR_SEED;
    clk              = 1'b0;
    rst_n            = 1'b0;
    issue_valid      = 1'b0;
    issue_type       = WB_INSTR_OTHER;
    issue_pc         = '0;
    issue_compressed = 1'b0;
    issue_count      = 1'b0;
    issue_rd         = '0;
    issue_rd_we      = 1'b0;
    issue_result     = '0;
    issue_store_data = '0;
    rf_raddr         = '0;
    raddr_q          = '0;
    cur              = '0;
    held             = '0;
    presenting       = 1'b0;
    inflight         = 1'b0;
    gap              = 0;
    issued           = 0;
    done_wait        = 0;
    ready_wait       = 0;
    pc_next          = 32'h0000_1000;
    clear_model();
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    check_after_reset();
    while (issued < NUM_INSTR || presenting || inflight) begin
      run_cycle();
    end
    // Let the last retirement reach the counters and the register file
    repeat (2) run_cycle();
    if (!model_err) abort_run("No out-of-range access was generated");
    // A second reset must clear the sticky error, the counters and the registers
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    clear_model();
    check_after_reset();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: verilog/axi_lite_if.sv
/*
 * AXI4-Lite bundle with manager and subordinate views
 */
`include "wb_defs.svh"

interface axi_lite_if;

  // Write address and write data channels
  logic [`WB_XLEN-1:0] awaddr;
  logic                awvalid;
  logic                awready;
  logic [`WB_XLEN-1:0] wdata;
  logic                wvalid;
  logic                wready;

  // Write response channel
  logic [1:0]          bresp;
  logic                bvalid;
  logic                bready;

  // Read address and read data channels
  logic [`WB_XLEN-1:0] araddr;
  logic                arvalid;
  logic                arready;
  logic [`WB_XLEN-1:0] rdata;
  logic [1:0]          rresp;
  logic                rvalid;
  logic                rready;

  modport manager (
    output awaddr, awvalid, wdata, wvalid, bready, araddr, arvalid, rready,
    input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
  );

  modport subordinate (
    input  awaddr, awvalid, wdata, wvalid, bready, araddr, arvalid, rready,
    output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
  );

endinterface

// File: verilog/wb_data_ram.sv
/*
 * AXI4-Lite word memory returning SLVERR outside its range
 */
`include "wb_defs.svh"

module wb_data_ram (
  input  logic            clk_i,
  input  logic            rst_ni,
  axi_lite_if.subordinate bus
);

  localparam int unsigned MEM_AW = $clog2(`WB_MEM_WORDS);
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  logic [`WB_XLEN-1:0] mem_q [`WB_MEM_WORDS];
  logic                wr_accept;
  logic                rd_accept;
  logic                wr_in_range;
  logic                rd_in_range;
  logic [MEM_AW-1:0]   wr_idx;
  logic [MEM_AW-1:0]   rd_idx;
  logic                bvalid_q;
  logic                rvalid_q;
  logic [1:0]          bresp_q;
  logic [1:0]          rresp_q;
  logic [`WB_XLEN-1:0] rdata_q;

  // A write is taken only with address and data both present and no response pending
  assign wr_accept   = bus.awvalid & bus.wvalid & ~bvalid_q;
  assign rd_accept   = bus.arvalid & ~rvalid_q;
  assign bus.awready = wr_accept;
  assign bus.wready  = wr_accept;
  assign bus.arready = ~rvalid_q;

  // Word index sits above the two byte-offset bits, anything higher must be zero
  assign wr_idx      = bus.awaddr[MEM_AW+1:2];
  assign rd_idx      = bus.araddr[MEM_AW+1:2];
  assign wr_in_range = (bus.awaddr[`WB_XLEN-1:MEM_AW+2] == '0);
  assign rd_in_range = (bus.araddr[`WB_XLEN-1:MEM_AW+2] == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `WB_MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_accept && wr_in_range) begin
      mem_q[wr_idx] <= bus.wdata;
    end
  end

  // Response valids rise one cycle after the accepting handshake and hold until taken
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_accept) bvalid_q <= 1'b1;
      else if (bus.bready) bvalid_q <= 1'b0;
      if (rd_accept) rvalid_q <= 1'b1;
      else if (bus.rready) rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_accept) bresp_q <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
    if (rd_accept) begin
      rresp_q <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
      // Out-of-range reads return zero
      rdata_q <= rd_in_range ? mem_q[rd_idx] : '0;
    end
  end

  assign bus.bvalid = bvalid_q;
  assign bus.bresp  = bresp_q;
  assign bus.rvalid = rvalid_q;
  assign bus.rresp  = rresp_q;
  assign bus.rdata  = rdata_q;

endmodule

// File: verilog/wb_defs.svh
/*
 * Width and size macros for the writeback subsystem
 */
`ifndef WB_DEFS_SVH
`define WB_DEFS_SVH

// Data and address width of the core
`define WB_XLEN 32

// Register file address width, giving 32 architectural registers
`define WB_REG_AW 5

// Data memory depth in 32-bit words, so byte addresses from 256 upwards are out of range
`define WB_MEM_WORDS 64

`endif

// File: verilog/wb_lsu.sv
/*
 * Load/store unit: one access at a time over an AXI4-Lite manager port
 */
`include "wb_defs.svh"

module wb_lsu import wb_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_i,
  input  wb_instr_type_e      type_i,
  input  logic [`WB_XLEN-1:0] addr_i,
  input  logic [`WB_XLEN-1:0] wdata_i,
  axi_lite_if.manager         bus,
  output lsu_resp_t           resp_o,
  output logic                err_o
);

  typedef enum logic [1:0] {LSU_IDLE, LSU_ADDR, LSU_RESP} lsu_state_e;

  lsu_state_e          state_q, state_d;
  logic                aw_pend_q, w_pend_q, ar_pend_q;
  logic                aw_pend_d, w_pend_d, ar_pend_d;
  logic                store_q;
  logic [`WB_XLEN-1:0] addr_q;
  logic [`WB_XLEN-1:0] wdata_q;
  logic                resp_hs;
  logic                resp_err;
  logic                take_req;
  logic                err_q;

  // Writeback is ready again in the cycle the response is handed back, so a new
  // access may start then as well as from idle
  assign take_req = req_i & ((state_q == LSU_IDLE) | resp_hs);

  // Each pending flag drives its channel valid and drops only on the handshake
  always_comb begin
    state_d   = state_q;
    aw_pend_d = aw_pend_q;
    w_pend_d  = w_pend_q;
    ar_pend_d = ar_pend_q;
    unique case (state_q)
      LSU_IDLE: begin
        // New requests are taken below
      end
      LSU_ADDR: begin
        if (bus.awready) aw_pend_d = 1'b0;
        if (bus.wready)  w_pend_d  = 1'b0;
        if (bus.arready) ar_pend_d = 1'b0;
        // Wait for the response once every address and data beat is gone
        if (!aw_pend_d && !w_pend_d && !ar_pend_d) state_d = LSU_RESP;
      end
      LSU_RESP: begin
        if (resp_hs) state_d = LSU_IDLE;
      end
      default: state_d = LSU_IDLE;
    endcase
    if (take_req) begin
      state_d   = LSU_ADDR;
      aw_pend_d = (type_i == WB_INSTR_STORE);
      w_pend_d  = (type_i == WB_INSTR_STORE);
      ar_pend_d = (type_i != WB_INSTR_STORE);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= LSU_IDLE;
      aw_pend_q <= 1'b0;
      w_pend_q  <= 1'b0;
      ar_pend_q <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      state_q   <= state_d;
      aw_pend_q <= aw_pend_d;
      w_pend_q  <= w_pend_d;
      ar_pend_q <= ar_pend_d;
      // Error flag is sticky until the next reset
      if (resp_hs && resp_err) err_q <= 1'b1;
    end
  end

  // Access attributes are captured when the request is taken
  always_ff @(posedge clk_i) begin
    if (take_req) begin
      store_q <= (type_i == WB_INSTR_STORE);
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
  end

  assign bus.awaddr  = addr_q;
  assign bus.awvalid = aw_pend_q;
  assign bus.wdata   = wdata_q;
  assign bus.wvalid  = w_pend_q;
  assign bus.araddr  = addr_q;
  assign bus.arvalid = ar_pend_q;
  // Responses are always accepted
  assign bus.bready  = 1'b1;
  assign bus.rready  = 1'b1;

  // Bit 1 of the response code is set for both SLVERR and DECERR
  assign resp_hs  = (state_q == LSU_RESP) & (store_q ? bus.bvalid : bus.rvalid);
  assign resp_err = store_q ? bus.bresp[1] : bus.rresp[1];

  assign resp_o.valid = resp_hs;
  assign resp_o.err   = resp_hs & resp_err;
  assign resp_o.rdata = bus.rdata;
  assign resp_o.we    = resp_hs & ~store_q & ~resp_err;
  assign err_o        = err_q;

  // Writeback back-pressure must keep a second request out while one is in flight
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i |-> (state_q == LSU_IDLE) || resp_hs);

endmodule

// File: verilog/wb_pkg.sv
/*
 * Shared types: instruction kind in writeback and the LSU response
 */
`include "wb_defs.svh"

package wb_pkg;

  // Kind of instruction held in the writeback stage
  // Loads and stores wait for the LSU, everything else finishes in one cycle
  typedef enum logic [1:0] {
    WB_INSTR_LOAD  = 2'b00,
    WB_INSTR_STORE = 2'b01,
    WB_INSTR_OTHER = 2'b10
  } wb_instr_type_e;

  // Response from the LSU to writeback, valid for exactly one cycle per access
  typedef struct packed {
    // Access has finished this cycle
    logic                valid;
    // Bus returned SLVERR or DECERR
    logic                err;
    // Read data, only meaningful for loads
    logic [`WB_XLEN-1:0] rdata;
    // Load finished without error and may write the register file
    logic                we;
  } lsu_resp_t;

endpackage

// File: verilog/wb_regfile.sv
/*
 * Integer register file, one write and one read port, x0 hardwired to zero
 */
`include "wb_defs.svh"

module wb_regfile (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [`WB_REG_AW-1:0] waddr_i,
  input  logic [`WB_XLEN-1:0]   wdata_i,
  input  logic                  we_i,
  input  logic [`WB_REG_AW-1:0] raddr_i,
  output logic [`WB_XLEN-1:0]   rdata_o
);

  localparam int unsigned NUM_REGS = 2 ** `WB_REG_AW;

  logic [`WB_XLEN-1:0] regs_q [NUM_REGS];

  // Writes to x0 are dropped so it keeps its reset value of zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Combinational read, a write shows up from the following cycle
  assign rdata_o = regs_q[raddr_i];

endmodule

// File: verilog/wb_retire_counters.sv
/*
 * Retired and retired-compressed instruction counters
 */
module wb_retire_counters (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        ret_i,
  input  logic        ret_compressed_i,
  output logic [31:0] retired_o,
  output logic [31:0] retired_compressed_o
);

  // Both counters wrap silently at 2**32
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      retired_o            <= '0;
      retired_compressed_o <= '0;
    end else begin
      if (ret_i) retired_o <= retired_o + 32'd1;
      if (ret_compressed_i) retired_compressed_o <= retired_compressed_o + 32'd1;
    end
  end

endmodule

// File: verilog/wb_stage.sv
/*
 * Writeback stage holding one instruction until it retires
 */
`include "wb_defs.svh"

module wb_stage import wb_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  en_wb_i,
  input  wb_instr_type_e        instr_type_i,
  input  logic [`WB_XLEN-1:0]   pc_i,
  input  logic                  compressed_i,
  input  logic                  count_i,
  input  logic [`WB_REG_AW-1:0] rd_i,
  input  logic                  rd_we_i,
  input  logic [`WB_XLEN-1:0]   result_i,
  input  lsu_resp_t             lsu_resp_i,
  output logic                  ready_o,
  output logic                  instr_done_o,
  output logic [`WB_XLEN-1:0]   pc_wb_o,
  output logic                  outstanding_load_o,
  output logic                  outstanding_store_o,
  output logic [`WB_REG_AW-1:0] rf_waddr_o,
  output logic [`WB_XLEN-1:0]   rf_wdata_o,
  output logic                  rf_we_o,
  output logic                  perf_ret_o,
  output logic                  perf_ret_compressed_o
);

  logic                  valid_q;
  logic                  done;
  logic                  we_other;
  logic                  we_load;
  wb_instr_type_e        type_q;
  logic [`WB_XLEN-1:0]   pc_q;
  logic                  compressed_q;
  logic                  count_q;
  logic [`WB_REG_AW-1:0] rd_q;
  logic                  rd_we_q;
  logic [`WB_XLEN-1:0]   result_q;

  // Non-memory instructions finish at once, memory ones when the LSU answers
  // Only meaningful while valid_q is set
  assign done = (type_q == WB_INSTR_OTHER) | lsu_resp_i.valid;

  // The stage fills on an accepted issue and empties once the held instruction is done
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= en_wb_i | (valid_q & ~done);
    end
  end

  // Instruction fields follow the valid bit and need no reset
  always_ff @(posedge clk_i) begin
    if (en_wb_i) begin
      type_q       <= instr_type_i;
      pc_q         <= pc_i;
      compressed_q <= compressed_i;
      count_q      <= count_i;
      rd_q         <= rd_i;
      rd_we_q      <= rd_we_i;
      result_q     <= result_i;
    end
  end

  // A new instruction may enter when the stage is empty or retires this cycle
  assign ready_o      = ~valid_q | done;
  assign instr_done_o = valid_q & done;
  assign pc_wb_o      = pc_q;

  assign outstanding_load_o  = valid_q & (type_q == WB_INSTR_LOAD);
  assign outstanding_store_o = valid_q & (type_q == WB_INSTR_STORE);

  // Two write sources share one port: the registered ALU result and load data from the LSU
  assign we_other   = valid_q & rd_we_q & (type_q == WB_INSTR_OTHER);
  assign we_load    = valid_q & lsu_resp_i.we;
  assign rf_we_o    = we_other | we_load;
  assign rf_wdata_o = we_load ? lsu_resp_i.rdata : result_q;
  assign rf_waddr_o = rd_q;

  // A faulting access still completes but is not counted as retired
  assign perf_ret_o            = instr_done_o & count_q & ~(lsu_resp_i.valid & lsu_resp_i.err);
  assign perf_ret_compressed_o = perf_ret_o & compressed_q;

  // LSU load data must never collide with an ALU write from this stage
  assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0({we_other, we_load}));

  // The LSU answers only while a memory instruction is held here
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsu_resp_i.valid |-> valid_q && (type_q != WB_INSTR_OTHER));

endmodule

// File: verilog/wb_top.sv
/*
 * Back-end top: writeback, LSU, data memory, register file and retire counters
 */
`include "wb_defs.svh"

module wb_top import wb_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  issue_valid_i,
  output logic                  issue_ready_o,
  input  wb_instr_type_e        issue_type_i,
  input  logic [`WB_XLEN-1:0]   issue_pc_i,
  input  logic                  issue_compressed_i,
  input  logic                  issue_count_i,
  input  logic [`WB_REG_AW-1:0] issue_rd_i,
  input  logic                  issue_rd_we_i,
  input  logic [`WB_XLEN-1:0]   issue_result_i,
  input  logic [`WB_XLEN-1:0]   issue_store_data_i,
  input  logic [`WB_REG_AW-1:0] rf_raddr_i,
  output logic [`WB_XLEN-1:0]   rf_rdata_o,
  output logic                  instr_done_o,
  output logic [`WB_XLEN-1:0]   pc_wb_o,
  output logic                  outstanding_load_o,
  output logic                  outstanding_store_o,
  output logic                  lsu_err_o,
  output logic [31:0]           retired_o,
  output logic [31:0]           retired_compressed_o
);

  logic                  issue_accept;
  logic                  lsu_req;
  lsu_resp_t             lsu_resp;
  logic [`WB_REG_AW-1:0] rf_waddr;
  logic [`WB_XLEN-1:0]   rf_wdata;
  logic                  rf_we;
  logic                  perf_ret;
  logic                  perf_ret_compressed;

  axi_lite_if dbus ();

  // An accepted memory instruction also starts its bus access in the same cycle
  assign issue_accept = issue_valid_i & issue_ready_o;
  assign lsu_req      = issue_accept & (issue_type_i != WB_INSTR_OTHER);

  wb_stage u_wb_stage (
    .clk_i, .rst_ni,
    .en_wb_i               (issue_accept),
    .instr_type_i          (issue_type_i),
    .pc_i                  (issue_pc_i),
    .compressed_i          (issue_compressed_i),
    .count_i               (issue_count_i),
    .rd_i                  (issue_rd_i),
    .rd_we_i               (issue_rd_we_i),
    .result_i              (issue_result_i),
    .lsu_resp_i            (lsu_resp),
    .ready_o               (issue_ready_o),
    .instr_done_o          (instr_done_o),
    .pc_wb_o               (pc_wb_o),
    .outstanding_load_o    (outstanding_load_o),
    .outstanding_store_o   (outstanding_store_o),
    .rf_waddr_o            (rf_waddr),
    .rf_wdata_o            (rf_wdata),
    .rf_we_o               (rf_we),
    .perf_ret_o            (perf_ret),
    .perf_ret_compressed_o (perf_ret_compressed)
  );

  // The issue result doubles as the memory address for loads and stores
  wb_lsu u_lsu (
    .clk_i, .rst_ni,
    .req_i   (lsu_req),
    .type_i  (issue_type_i),
    .addr_i  (issue_result_i),
    .wdata_i (issue_store_data_i),
    .bus     (dbus.manager),
    .resp_o  (lsu_resp),
    .err_o   (lsu_err_o)
  );

  wb_data_ram u_data_ram (
    .clk_i, .rst_ni,
    .bus (dbus.subordinate)
  );

  wb_regfile u_regfile (
    .clk_i, .rst_ni,
    .waddr_i (rf_waddr),
    .wdata_i (rf_wdata),
    .we_i    (rf_we),
    .raddr_i (rf_raddr_i),
    .rdata_o (rf_rdata_o)
  );

  wb_retire_counters u_counters (
    .clk_i, .rst_ni,
    .ret_i                (perf_ret),
    .ret_compressed_i     (perf_ret_compressed),
    .retired_o            (retired_o),
    .retired_compressed_o (retired_compressed_o)
  );

endmodule
